// File: verilog.f
+incdir+verilog
verilog/cnn_pkg.sv
verilog/word_ram.sv
verilog/tile_sequencer.sv
verilog/dot_pack.sv
verilog/acc_writeback.sv
verilog/class_select.sv
verilog/cnn_dense_top.sv
testbench/cnn_dense_chk.sv
testbench/cnn_dense_tb.sv

// File: Bender.yml
package:
  name: cnn_dense

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cnn_pkg.sv
      - verilog/word_ram.sv
      - verilog/tile_sequencer.sv
      - verilog/dot_pack.sv
      - verilog/acc_writeback.sv
      - verilog/class_select.sv
      - verilog/cnn_dense_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/cnn_dense_chk.sv
      - testbench/cnn_dense_tb.sv

// File: testbench/cnn_cases.txt
# name n_out k_grp weight_fill feature_fill class
# fill: signed lane value, randN (N random bits per lane) or keep; class: index or -
ones_k2 4 2 1 1 0
relu_neg 3 2 -1 5 0
sat_big 5 3 20 30 0
single 1 1 3 -4 0
rand_small 4 3 rand2 rand2 -
rand_mid 8 4 rand3 rand2 -
rand_wide 6 2 rand8 rand8 -
rand_full 16 16 rand2 rand2 -
rand_tall 16 1 rand3 rand3 -
rand_deep 2 16 rand2 rand2 -
b2b_first 10 5 rand2 rand2 -
b2b_second 10 5 keep rand2 -
b2b_third 10 5 keep rand3 -
ones_again 4 2 1 1 0

// File: testbench/cnn_dense_tb.sv
// --------------------
// cases from testbench/cnn_cases.txt; keep reuses the previous weights
// stops at the first mismatch
// --------------------
`include "cnn_settings.svh"

module cnn_dense_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cnn_pkg::*;

  localparam int RES_MAX = 127;

  logic    clk = 1'b0;
  logic    rst;
  logic    load_en, load_sel, start;
  waddr_t  load_addr;
  word_u   load_data;
  n_idx_t  n_out, res_addr, class_idx;
  kg_idx_t k_grp;
  logic    busy, done;
  lane_t   res_data;

  logic [31:0] lfsr_state = 32'h9b74_72d2;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  word_u       w_mem [`W_DEPTH];
  word_u       f_mem [`MAX_KG];
  int          exp_res [`MAX_N];

  string case_name [$];
  string w_fill [$];
  string f_fill [$];
  string cls_tok [$];
  int    case_n [$];
  int    case_k [$];

  cnn_dense_top u_dut (
    .clk(clk), .rst(rst), .load_en(load_en), .load_sel(load_sel),
    .load_addr(load_addr), .load_data(load_data), .start(start),
    .n_out(n_out), .k_grp(k_grp), .res_addr(res_addr),
    .busy(busy), .done(done), .class_idx(class_idx), .res_data(res_data)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  // --------------------
  // cycle limit and assertion watch
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
    if (u_dut.u_chk.assert_fails != 0) begin
      abort_run("a concurrent assertion in cnn_dense_chk failed");
    end
  end

  task automatic check_lane(input string test, input string what,
                            input lane_t exp, input lane_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s %s: expected %0d, got %0d", test, what, exp, act));
    end
  endtask

  task automatic check_idx(input string test, input string what,
                           input n_idx_t exp, input n_idx_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s %s: expected %0d, got %0d", test, what, exp, act));
    end
  endtask

  task automatic check_cycles(input string test, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("ERR %s done latency: expected %0d, got %0d", test, exp, act));
    end
  endtask

  // --------------------
  // stimulus
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;  // taps 32 22 2 1
    end
    return out;
  endfunction

  function automatic lane_t rand_lane(input int bits);
    int v;
    v = 0;
    for (int i = 0; i < bits; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    if (v >= (1 << (bits - 1))) begin
      v = v - (1 << bits);  // sign extend
    end
    return lane_t'(v);
  endfunction

  // lane value, or randN for N random bits per lane
  function automatic word_u fill_word(input string tok);
    word_u wd;
    int    bits;
    int    val;
    bits = 0;
    val = 0;
    if (tok.len() > 4 && tok.substr(0, 3) == "rand") begin
      void'($sscanf(tok.substr(4, tok.len() - 1), "%d", bits));
    end else begin
      void'($sscanf(tok, "%d", val));
    end
    for (int i = 0; i < `PACK; i++) begin
      wd.lanes[i] = (bits > 0) ? rand_lane(bits) : lane_t'(val);
    end
    return wd;
  endfunction

  // results into exp_res, returns the arg-max
  function automatic int model_class(input int n, input int k);
    int total;
    int best;
    for (int nn = 0; nn < n; nn++) begin
      total = 0;
      for (int kk = 0; kk < k; kk++) begin
        for (int i = 0; i < `PACK; i++) begin
          total += int'($signed(w_mem[nn * k + kk].lanes[i])) *
                   int'($signed(f_mem[kk].lanes[i]));
        end
      end
      exp_res[nn] = (total < 0) ? 0 : ((total > RES_MAX) ? RES_MAX : total);
    end
    best = 0;
    for (int nn = 1; nn < n; nn++) begin
      if (exp_res[nn] > exp_res[best]) begin
        best = nn;  // lowest index wins ties
      end
    end
    return best;
  endfunction

  task automatic load_word(input logic sel, input int addr, input word_u data);
    @(negedge clk);
    load_en   = 1'b1;
    load_sel  = sel;
    load_addr = waddr_t'(addr);
    load_data = data;
  endtask

  task automatic run_case(input int idx);
    string name;
    int    n;
    int    k;
    int    cls;
    int    edges;
    name = case_name[idx];
    n = case_n[idx];
    k = case_k[idx];
    if (w_fill[idx] != "keep") begin
      for (int nn = 0; nn < n; nn++) begin
        for (int kk = 0; kk < k; kk++) begin
          w_mem[nn * k + kk] = fill_word(w_fill[idx]);
          load_word(1'b0, nn * k + kk, w_mem[nn * k + kk]);
        end
      end
    end
    for (int kk = 0; kk < k; kk++) begin
      f_mem[kk] = fill_word(f_fill[idx]);
      load_word(1'b1, kk, f_mem[kk]);
    end
    cls = model_class(n, k);
    if (cls_tok[idx] != "-") begin
      void'($sscanf(cls_tok[idx], "%d", cls));
    end
    @(negedge clk);
    load_en = 1'b0;
    n_out   = n_idx_t'(n);
    k_grp   = kg_idx_t'(k);
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    edges = 0;  // rising edges since the one that took start
    while (!done) begin
      if (!busy) begin
        abort_run($sformatf("%s: busy dropped before done", name));
      end
      @(negedge clk);
      edges++;
    end
    check_cycles(name, n * k + 3, edges);
    if (busy) begin
      abort_run($sformatf("%s: busy still high with done", name));
    end
    check_idx(name, "class_idx", n_idx_t'(cls), class_idx);
    for (int nn = 0; nn < n; nn++) begin
      res_addr = n_idx_t'(nn);
      @(negedge clk);
      check_lane(name, $sformatf("res[%0d]", nn), lane_t'(exp_res[nn]), res_data);
    end
    check_idx(name, "held class_idx", n_idx_t'(cls), class_idx);
  endtask

  // --------------------
  initial begin : main
    int    fd;
    int    cnt;
    int    n;
    int    k;
    string line;
    string nm, wt, ft, ct;
    rst       = 1'b1;
    load_en   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    n_out     = '0;
    k_grp     = '0;
    res_addr  = '0;
    fd = $fopen("testbench/cnn_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open testbench/cnn_cases.txt");
    end
    cycle_limit = 4 + 50;  // reset plus margin
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.substr(0, 0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %d %d %s %s %s", nm, n, k, wt, ft, ct);
      if (cnt <= 0) begin
        continue;
      end
      if (cnt != 6 || n < 1 || n > `MAX_N || k < 1 || k > `MAX_KG) begin
        abort_run($sformatf("malformed case line: %s", line));
      end
      if (wt == "keep" && (case_n.size() == 0 || case_n[$] != n || case_k[$] != k)) begin
        abort_run($sformatf("case %s keeps weights of a different size", nm));
      end
      case_name.push_back(nm);
      case_n.push_back(n);
      case_k.push_back(k);
      w_fill.push_back(wt);
      f_fill.push_back(ft);
      cls_tok.push_back(ct);
      // loads, run, readback
      cycle_limit += ((wt == "keep") ? 0 : n * k) + k + 2 + n * k + 5 + n + 2;
    end
    $fclose(fd);
    if (case_name.size() == 0) begin
      abort_run("case file holds no cases");
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (case_name[i]) begin
      run_case(i);
    end
    @(negedge clk);
    if (u_dut.u_chk.assert_fails == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("a concurrent assertion in cnn_dense_chk failed");
    end
  end

endmodule

// File: testbench/cnn_dense_chk.sv
// --------------------
// protocol checks, bound into cnn_dense_top
// n_out must stay stable while a run is busy
// --------------------
module cnn_dense_chk (
  input logic            clk,
  input logic            rst,
  input logic            load_en,
  input logic            busy,
  input logic            done,
  input cnn_pkg::n_idx_t n_out,
  input cnn_pkg::n_idx_t class_idx
);
  timeunit 1ns;
  timeprecision 100ps;

  int assert_fails = 0;

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      assert_fails++;
    end

  a_idle_after_rst: assert property (@(posedge clk) rst |=> !busy)
    else begin
      $error("busy not low after reset");
      assert_fails++;
    end

  // memories are only written while idle
  a_no_load_busy: assert property (@(posedge clk) disable iff (rst) load_en |-> !busy)
    else begin
      $error("load_en asserted while busy");
      assert_fails++;
    end

  a_class_range: assert property (@(posedge clk) disable iff (rst) done |-> class_idx < n_out)
    else begin
      $error("class_idx out of range at done");
      assert_fails++;
    end

endmodule

bind cnn_dense_top cnn_dense_chk u_chk (
  .clk(clk), .rst(rst), .load_en(load_en), .busy(busy), .done(done),
  .n_out(n_out), .class_idx(class_idx)
);

// File: verilog/cnn_dense_top.sv
// --------------------
// single dense layer engine; memories are loaded only while idle
// load_sel 0 = weights at n*k_grp+k, 1 = features at k
// --------------------
`include "cnn_settings.svh"

module cnn_dense_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             load_en,
  input  logic             load_sel,
  input  cnn_pkg::waddr_t  load_addr,
  input  cnn_pkg::word_u   load_data,
  input  logic             start,
  input  cnn_pkg::n_idx_t  n_out,
  input  cnn_pkg::kg_idx_t k_grp,
  input  cnn_pkg::n_idx_t  res_addr,
  output logic             busy,
  output logic             done,
  output cnn_pkg::n_idx_t  class_idx,
  output cnn_pkg::lane_t   res_data
);
  import cnn_pkg::*;

  localparam int FAW = $clog2(`MAX_KG);

  logic    w_we, f_we;
  logic    run_start;  // start that the sequencer accepts
  waddr_t  w_raddr;
  kg_idx_t f_raddr;
  word_u   w_word, f_word;
  n_idx_t  tag_n, dot_n, res_n;
  logic    tag_first, tag_last, tag_valid;
  logic    dot_first, dot_last, dot_valid;
  acc_t    dot_sum;
  logic    res_we;
  lane_t   res_val;

  assign w_we      = load_en & ~load_sel;
  assign f_we      = load_en & load_sel;
  assign run_start = start & ~busy;

  // --------------------
  word_ram #(.DEPTH(`W_DEPTH)) u_wram (
    .clk(clk), .we(w_we), .waddr(load_addr), .wdata(load_data),
    .raddr(w_raddr), .rdata(w_word)
  );

  word_ram #(.DEPTH(`MAX_KG)) u_fram (
    .clk(clk), .we(f_we), .waddr(load_addr[FAW-1:0]), .wdata(load_data),
    .raddr(f_raddr[FAW-1:0]), .rdata(f_word)
  );

  tile_sequencer u_seq (
    .clk(clk), .rst(rst), .start(start), .n_out(n_out), .k_grp(k_grp),
    .w_raddr(w_raddr), .f_raddr(f_raddr), .tag_n(tag_n),
    .tag_first(tag_first), .tag_last(tag_last), .tag_valid(tag_valid),
    .busy(busy), .done(done)
  );

  dot_pack u_dot (
    .clk(clk), .rst(rst), .w(w_word), .f(f_word),
    .in_n(tag_n), .in_first(tag_first), .in_last(tag_last), .in_valid(tag_valid),
    .sum(dot_sum), .out_n(dot_n),
    .out_first(dot_first), .out_last(dot_last), .out_valid(dot_valid)
  );

  acc_writeback u_acc (
    .clk(clk), .rst(rst), .sum(dot_sum),
    .in_n(dot_n), .in_first(dot_first), .in_last(dot_last), .in_valid(dot_valid),
    .res_we(res_we), .res_n(res_n), .res_val(res_val)
  );

  class_select u_cls (
    .clk(clk), .rst(rst), .start(run_start),
    .res_we(res_we), .res_n(res_n), .res_val(res_val),
    .res_addr(res_addr), .res_data(res_data), .class_idx(class_idx)
  );

endmodule

// File: verilog/class_select.sv
// --------------------
// result buffer with registered readback, running arg-max
// results are assumed to arrive in increasing n order
// --------------------
`include "cnn_settings.svh"

module class_select (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            res_we,
  input  cnn_pkg::n_idx_t res_n,
  input  cnn_pkg::lane_t  res_val,
  input  cnn_pkg::n_idx_t res_addr,
  output cnn_pkg::lane_t  res_data,
  output cnn_pkg::n_idx_t class_idx
);
  import cnn_pkg::*;

  localparam int IW = $clog2(`MAX_N);

  lane_t res_buf [`MAX_N];
  lane_t max_val;

  always_ff @(posedge clk) begin
    if (res_we) begin
      res_buf[res_n[IW-1:0]] <= res_val;
    end
    res_data <= res_buf[res_addr[IW-1:0]];
  end

  // --------------------
  // strictly greater keeps the lowest index on ties
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      max_val   <= '0;
      class_idx <= '0;
    end else if (start) begin
      max_val   <= '0;  // results are never negative after ReLU
      class_idx <= '0;
    end else if (res_we && (res_val > max_val)) begin
      max_val   <= res_val;
      class_idx <= res_n;
    end
  end

endmodule

// File: verilog/acc_writeback.sv
// --------------------
// running partial sum per output; ReLU and clamp to the positive lane range
// expects the k-groups of one output back to back, first to last
// --------------------
`include "cnn_settings.svh"

module acc_writeback (
  input  logic            clk,
  input  logic            rst,
  input  cnn_pkg::acc_t   sum,
  input  cnn_pkg::n_idx_t in_n,
  input  logic            in_first,
  input  logic            in_last,
  input  logic            in_valid,
  output logic            res_we,
  output cnn_pkg::n_idx_t res_n,
  output cnn_pkg::lane_t  res_val
);
  import cnn_pkg::*;

  localparam acc_t SAT_HI = acc_t'((1 << (`LANE_W - 1)) - 1);  // 127 for 8-bit lanes

  acc_t  acc;
  acc_t  total;
  lane_t clipped;

  assign total = in_first ? sum : acc + sum;

  always_comb begin
    if (total < 0) begin
      clipped = '0;
    end else if (total > SAT_HI) begin
      clipped = lane_t'(SAT_HI);
    end else begin
      clipped = lane_t'(total);
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      acc <= total;
    end
    if (in_valid && in_last) begin
      res_n   <= in_n;
      res_val <= clipped;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_we <= 1'b0;
    end else begin
      res_we <= in_valid & in_last;  // one strobe per output
    end
  end

endmodule

// File: verilog/dot_pack.sv
// --------------------
// PACK signed lane products summed in a binary tree, one register stage
// --------------------
`include "cnn_settings.svh"

module dot_pack (
  input  logic            clk,
  input  logic            rst,
  input  cnn_pkg::word_u  w,
  input  cnn_pkg::word_u  f,
  input  cnn_pkg::n_idx_t in_n,
  input  logic            in_first,
  input  logic            in_last,
  input  logic            in_valid,
  output cnn_pkg::acc_t   sum,
  output cnn_pkg::n_idx_t out_n,
  output logic            out_first,
  output logic            out_last,
  output logic            out_valid
);
  import cnn_pkg::*;

  acc_t tree [`PACK];

  always_comb begin
    for (int i = 0; i < `PACK; i++) begin
      tree[i] = acc_t'($signed(w.lanes[i])) * acc_t'($signed(f.lanes[i]));
    end
    // pairwise reduction, result ends in tree[0]
    for (int step = 1; step < `PACK; step = step * 2) begin
      for (int i = 0; i + step < `PACK; i = i + 2 * step) begin
        tree[i] = tree[i] + tree[i + step];
      end
    end
  end

  always_ff @(posedge clk) begin
    sum <= tree[0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_n     <= '0;
      out_first <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= in_valid;
      out_n     <= in_n;
      out_first <= in_first;
      out_last  <= in_last;
    end
  end

endmodule

// File: verilog/tile_sequencer.sv
// --------------------
// n_out and k_grp must be nonzero; start is ignored while busy
// done comes n_out*k_grp+3 cycles after the accepted start
// --------------------
module tile_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  cnn_pkg::n_idx_t  n_out,
  input  cnn_pkg::kg_idx_t k_grp,
  output cnn_pkg::waddr_t  w_raddr,
  output cnn_pkg::kg_idx_t f_raddr,
  output cnn_pkg::n_idx_t  tag_n,
  output logic             tag_first,
  output logic             tag_last,
  output logic             tag_valid,
  output logic             busy,
  output logic             done
);
  import cnn_pkg::*;

  n_idx_t     n_lim, n_cnt;
  kg_idx_t    k_lim, k_cnt;
  waddr_t     row_base;  // n_cnt * k_lim as a running sum
  logic       issuing;
  logic       last_k, last_n;
  logic [2:0] drain;     // ram, dot, acc stages behind the final issue

  assign last_k  = (k_cnt == k_lim - 1'b1);
  assign last_n  = (n_cnt == n_lim - 1'b1);
  assign w_raddr = row_base + waddr_t'(k_cnt);
  assign f_raddr = k_cnt;

  // --------------------
  // counters, k inner, n outer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy     <= 1'b0;
      issuing  <= 1'b0;
      n_lim    <= '0;
      k_lim    <= '0;
      n_cnt    <= '0;
      k_cnt    <= '0;
      row_base <= '0;
      drain    <= '0;
      done     <= 1'b0;
    end else begin
      drain <= {drain[1:0], issuing & last_k & last_n};
      done  <= drain[2];
      if (start && !busy) begin
        busy     <= 1'b1;
        issuing  <= 1'b1;
        n_lim    <= n_out;
        k_lim    <= k_grp;
        n_cnt    <= '0;
        k_cnt    <= '0;
        row_base <= '0;
      end else begin
        if (drain[2]) begin
          busy <= 1'b0;  // falls together with done
        end
        if (issuing) begin
          if (last_k) begin
            k_cnt    <= '0;
            row_base <= row_base + waddr_t'(k_lim);
            if (last_n) begin
              issuing <= 1'b0;
            end else begin
              n_cnt <= n_cnt + 1'b1;
            end
          end else begin
            k_cnt <= k_cnt + 1'b1;
          end
        end
      end
    end
  end

  // --------------------
  // tag lines up with registered ram data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tag_valid <= 1'b0;
      tag_n     <= '0;
      tag_first <= 1'b0;
      tag_last  <= 1'b0;
    end else begin
      tag_valid <= issuing;
      tag_n     <= n_cnt;
      tag_first <= (k_cnt == '0);
      tag_last  <= last_k;
    end
  end

endmodule

// File: verilog/word_ram.sv
// --------------------
// simple dual-port word memory, registered read, no read-during-write bypass
// contents are undefined until loaded
// --------------------
module word_ram #(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  cnn_pkg::word_u           wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output cnn_pkg::word_u           rdata
);
  import cnn_pkg::*;

  logic [$bits(word_u)-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata.flat;
    end
    rdata.flat <= mem[raddr];  // one cycle read latency
  end

endmodule

// File: verilog/cnn_pkg.sv
// --------------------
// types shared by the dense engine, sized from cnn_settings.svh
// --------------------
`include "cnn_settings.svh"

package cnn_pkg;

  typedef logic signed [`LANE_W-1:0] lane_t;

  // one memory word: flat for load/storage, lanes for the dot product
  typedef union packed {
    logic [`PACK*`LANE_W-1:0] flat;
    lane_t [`PACK-1:0]        lanes;
  } word_u;

  typedef logic signed [`ACC_W-1:0] acc_t;

  // counts go up to MAX_N / MAX_KG, hence the extra bit
  typedef logic [$clog2(`MAX_N):0]  n_idx_t;
  typedef logic [$clog2(`MAX_KG):0] kg_idx_t;

  typedef logic [$clog2(`W_DEPTH)-1:0] waddr_t;

endpackage

// File: verilog/cnn_settings.svh
// --------------------
// engine sizing; W_DEPTH must cover MAX_N * MAX_KG words
// PACK is assumed to be a power of two
// --------------------
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

`define PACK     8    // lanes per packed word
`define LANE_W   8
`define ACC_W    24
`define MAX_N    16
`define MAX_KG   16
`define W_DEPTH  (`MAX_N * `MAX_KG)

`endif
